/* files.f */
rvIsaPkg.sv
rvCtrlPkg.sv
ctrlIf.sv
instrDecoder.sv
regFile.sv
aluUnit.sv
csrFile.sv
pcSequencer.sv
rvCore.sv
tbClock.sv
tbCore.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f files.f --top-module tbCore -o simCore
./obj_dir/simCore 2>&1 | tee sim.log

if grep -q "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tbCore.sv */
module tbCore;
    timeunit 1ns;
    timeprecision 1ps;
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 5;
    localparam int IdleCycles  = 4;
    // Upper bound on instructions sent; each one takes two clocks.
    localparam int InstrBudget = 100;
    localparam int WatchdogNs  = (ResetCycles + IdleCycles + InstrBudget * 2) * ClkPeriod * 2;

    logic    clk;
    logic    arstN;
    xlenT    instr;
    logic    instrValid;
    xlenT    memAddr;
    xlenT    memWdata;
    logic    memRead;
    memSizeT memWrite;
    xlenT    memRdata;
    xlenT    pc;
    logic    retValid;
    regIdxT  retRd;
    xlenT    retData;

    xlenT        regModel [32];
    xlenT        mem [256];
    xlenT        expPc;
    xlenT        retired;
    logic        squashNext;
    logic [31:0] rngState;

    tbClock uClock (.clk(clk), .arstN(arstN));

    rvCore dut (
        .clk(clk), .arstN(arstN), .instr(instr), .instrValid(instrValid),
        .memAddr(memAddr), .memWdata(memWdata), .memRead(memRead), .memWrite(memWrite),
        .memRdata(memRdata), .pc(pc), .retValid(retValid), .retRd(retRd), .retData(retData)
    );

    function automatic xlenT fillWord(input int idx);
        return 32'h5A00_0000 ^ (idx * 32'h0101_0101);
    endfunction

    // Word-addressed data memory with a combinational read port.
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = fillWord(i);
        end
    end

    assign memRdata = mem[memAddr[9:2]];

    always @(posedge clk) begin
        case (memWrite)
            BYTE:    mem[memAddr[9:2]][8 * memAddr[1:0] +: 8] = memWdata[7:0];
            HALF:    mem[memAddr[9:2]][16 * memAddr[1] +: 16] = memWdata[15:0];
            WORD:    mem[memAddr[9:2]] = memWdata;
            default: ;
        endcase
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout: the tests did not finish in the expected time");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic xlenT rType(input logic [6:0] f7, input regIdxT rs2, input regIdxT rs1,
                                   input funct3T f3, input regIdxT rd, input opcodeT op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic xlenT iType(input logic [11:0] imm, input regIdxT rs1, input funct3T f3,
                                   input regIdxT rd, input opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic xlenT sType(input logic [11:0] imm, input regIdxT rs2, input regIdxT rs1,
                                   input funct3T f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic xlenT bType(input logic [12:0] off, input regIdxT rs2, input regIdxT rs1,
                                   input funct3T f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic xlenT uType(input logic [19:0] imm, input regIdxT rd, input opcodeT op);
        return {imm, rd, op};
    endfunction

    function automatic xlenT jType(input logic [20:0] off, input regIdxT rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    // RV32I integer semantics; alt is instruction bit 30.
    function automatic xlenT arithResult(input funct3T f3, input logic alt, input xlenT a,
                                         input xlenT b);
        xlenT r;
        case (f3)
            F3_ADD:  r = alt ? a - b : a + b;
            F3_SLL:  r = a << b[4:0];
            F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  r = a ^ b;
            F3_SR: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            F3_OR:   r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchTaken(input funct3T f3, input xlenT a, input xlenT b);
        case (f3)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            BGEU:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic issueInstr(input xlenT ins);
        @(posedge clk);
        instr      <= ins;
        instrValid <= 1'b1;
        @(negedge clk);
    endtask

    // Checks the retire report and pc one cycle after the accepting edge.
    task automatic acceptInstr(input logic writes, input regIdxT rd, input xlenT data,
                               input logic jumps, input xlenT tgt);
        logic expRet;
        @(posedge clk);
        instrValid <= 1'b0;
        if (squashNext) begin
            expRet     = 1'b0;
            squashNext = 1'b0;
        end else begin
            expRet = writes && rd != 5'd0;
            if (expRet) regModel[rd] = data;
            expPc      = jumps ? tgt : expPc + 32'd4;
            squashNext = jumps;
            retired    = retired + 32'd1;
        end
        @(negedge clk);
        checkValue("retValid", {31'b0, retValid}, {31'b0, expRet});
        if (expRet) begin
            checkValue("retRd", {27'b0, retRd}, {27'b0, rd});
            checkValue("retData", retData, data);
        end
        checkValue("pc", pc, expPc);
    endtask

    task automatic runInstr(input xlenT ins, input logic writes, input regIdxT rd, input xlenT data);
        issueInstr(ins);
        acceptInstr(writes, rd, data, 1'b0, 32'h0);
    endtask

    task automatic runSquashed(input xlenT ins);
        issueInstr(ins);
        checkValue("memWrite", {30'b0, memWrite}, {30'b0, IDLE});
        checkValue("memRead", {31'b0, memRead}, 32'h0);
        acceptInstr(1'b1, 5'd7, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic loadReg(input regIdxT rd, input xlenT v);
        xlenT hi;
        hi = v + 32'h800;
        runInstr(uType(hi[31:12], rd, LUI), 1'b1, rd, {hi[31:12], 12'h000});
        runInstr(iType(v[11:0], rd, F3_ADD, rd, OP_IMM), 1'b1, rd, v);
    endtask

    task automatic resetState();
        wait (arstN === 1'b1);
        @(negedge clk);
        checkValue("pc", pc, 32'h0);
        checkValue("retValid", {31'b0, retValid}, 32'h0);
        // Loads and stores offered without instrValid.
        for (int i = 0; i < IdleCycles; i++) begin
            @(posedge clk);
            if (i[0]) begin
                instr <= sType(12'h010, 5'd2, 5'd0, SW);
            end else begin
                instr <= iType(12'h010, 5'd0, LW, 5'd7, LOAD);
            end
            instrValid <= 1'b0;
            @(negedge clk);
            checkValue("pc", pc, 32'h0);
            checkValue("retValid", {31'b0, retValid}, 32'h0);
            checkValue("memWrite", {30'b0, memWrite}, {30'b0, IDLE});
            checkValue("memRead", {31'b0, memRead}, 32'h0);
        end
    endtask

    task automatic arithOps();
        logic [31:0] r;
        logic [11:0] imm;
        regIdxT      rd;
        loadReg(5'd1, nextRand());
        loadReg(5'd2, nextRand());
        runInstr(uType(20'h12345, 5'd5, AUIPC), 1'b1, 5'd5, expPc + 32'h1234_5000);
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    rd = regIdxT'(3 + alt);
                    runInstr(rType(alt[0] ? 7'h20 : 7'h00, 5'd2, 5'd1, funct3T'(f), rd, OP),
                             1'b1, rd,
                             arithResult(funct3T'(f), alt[0], regModel[1], regModel[2]));
                end
            end
        end
        for (int f = 0; f < 8; f++) begin
            r   = nextRand();
            imm = r[11:0];
            if (f == 1 || f == 5) imm = {7'h00, r[4:0]};
            runInstr(iType(imm, 5'd1, funct3T'(f), 5'd3, OP_IMM), 1'b1, 5'd3,
                     arithResult(funct3T'(f), 1'b0, regModel[1], {{20{imm[11]}}, imm}));
            if (f == 5) begin
                imm = {7'h20, r[4:0]};
                runInstr(iType(imm, 5'd1, F3_SR, 5'd4, OP_IMM), 1'b1, 5'd4,
                         arithResult(F3_SR, 1'b1, regModel[1], {27'b0, r[4:0]}));
            end
        end
        // Writes to x0 are dropped.
        runInstr(iType(12'h005, 5'd1, F3_ADD, 5'd0, OP_IMM), 1'b1, 5'd0, regModel[1] + 32'd5);
        runInstr(rType(7'h00, 5'd1, 5'd0, F3_ADD, 5'd4, OP), 1'b1, 5'd4, regModel[1]);
    endtask

    task automatic storeLoad();
        xlenT w0;
        xlenT w1;
        loadReg(5'd6, 32'h100);
        issueInstr(sType(12'd0, 5'd2, 5'd6, SW));
        checkValue("memWrite", {30'b0, memWrite}, {30'b0, WORD});
        checkValue("memAddr", memAddr, 32'h100);
        checkValue("memWdata", memWdata, regModel[2]);
        checkValue("memRead", {31'b0, memRead}, 32'h0);
        acceptInstr(1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        w0 = regModel[2];
        issueInstr(sType(12'd1, 5'd1, 5'd6, SB));
        checkValue("memWrite", {30'b0, memWrite}, {30'b0, BYTE});
        checkValue("memAddr", memAddr, 32'h101);
        checkValue("memWdata", memWdata, regModel[1]);
        acceptInstr(1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        w0 = {w0[31:16], regModel[1][7:0], w0[7:0]};
        issueInstr(sType(12'd2, 5'd1, 5'd6, SH));
        checkValue("memWrite", {30'b0, memWrite}, {30'b0, HALF});
        checkValue("memAddr", memAddr, 32'h102);
        acceptInstr(1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        w0 = {regModel[1][15:0], w0[15:0]};
        issueInstr(sType(12'd7, 5'd2, 5'd6, SB));
        checkValue("memWrite", {30'b0, memWrite}, {30'b0, BYTE});
        checkValue("memAddr", memAddr, 32'h107);
        acceptInstr(1'b0, 5'd0, 32'h0, 1'b0, 32'h0);
        w1 = fillWord(32'h41);
        w1 = {regModel[2][7:0], w1[23:0]};
        issueInstr(iType(12'd0, 5'd6, LW, 5'd7, LOAD));
        checkValue("memRead", {31'b0, memRead}, 32'h1);
        checkValue("memWrite", {30'b0, memWrite}, {30'b0, IDLE});
        acceptInstr(1'b1, 5'd7, w0, 1'b0, 32'h0);
        issueInstr(iType(12'd4, 5'd6, LW, 5'd7, LOAD));
        checkValue("memAddr", memAddr, 32'h104);
        acceptInstr(1'b1, 5'd7, w1, 1'b0, 32'h0);
    endtask

    task automatic branchKinds();
        funct3T      kinds [6];
        regIdxT      srcA;
        regIdxT      srcB;
        logic [12:0] off;
        logic        cond;
        kinds = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                srcA = (p == 1) ? 5'd2 : 5'd1;
                srcB = (p == 0) ? 5'd2 : 5'd1;
                // Offset of -12 or +24 bytes.
                off  = (p == 1) ? 13'h1FF4 : 13'h0018;
                cond = branchTaken(kinds[k], regModel[srcA], regModel[srcB]);
                issueInstr(bType(off, srcB, srcA, kinds[k]));
                acceptInstr(1'b0, 5'd0, 32'h0, cond, expPc + {{19{off[12]}}, off});
                if (cond) begin
                    case (p)
                        0:       runSquashed(sType(12'd0, 5'd2, 5'd6, SW));
                        1:       runSquashed(iType(12'd1, 5'd1, F3_ADD, 5'd7, OP_IMM));
                        default: runSquashed(iType(12'd0, 5'd6, LW, 5'd7, LOAD));
                    endcase
                end
            end
        end
    endtask

    task automatic jumpLinks();
        issueInstr(jType(21'h000400, 5'd8));
        acceptInstr(1'b1, 5'd8, expPc + 32'd4, 1'b1, expPc + 32'h400);
        runSquashed(rType(7'h00, 5'd2, 5'd1, F3_ADD, 5'd7, OP));
        issueInstr(jType(21'h1FFFF8, 5'd8));
        acceptInstr(1'b1, 5'd8, expPc + 32'd4, 1'b1, expPc - 32'd8);
        runSquashed(sType(12'd0, 5'd2, 5'd6, SW));
        loadReg(5'd10, 32'h2340);
        issueInstr(iType(12'h003, 5'd10, 3'b000, 5'd9, JALR));
        acceptInstr(1'b1, 5'd9, expPc + 32'd4, 1'b1, (regModel[10] + 32'd3) & ~32'h1);
        runSquashed(iType(12'd0, 5'd6, LW, 5'd7, LOAD));
    endtask

    task automatic csrAccess();
        xlenT scratch;
        scratch = 32'h0;
        runInstr(iType(CSR_MSCRATCH, 5'd1, CSRRW, 5'd11, SYSTEM), 1'b1, 5'd11, scratch);
        scratch = regModel[1];
        runInstr(iType(CSR_MSCRATCH, 5'd2, CSRRS, 5'd12, SYSTEM), 1'b1, 5'd12, scratch);
        scratch = scratch | regModel[2];
        runInstr(iType(CSR_MSCRATCH, 5'd1, CSRRC, 5'd13, SYSTEM), 1'b1, 5'd13, scratch);
        scratch = scratch & ~regModel[1];
        runInstr(iType(CSR_MSCRATCH, 5'd0, CSRRS, 5'd14, SYSTEM), 1'b1, 5'd14, scratch);
        // minstret ignores writes and counts only executed instructions.
        runInstr(iType(CSR_MINSTRET, 5'd0, CSRRS, 5'd15, SYSTEM), 1'b1, 5'd15, retired);
        runInstr(iType(CSR_MINSTRET, 5'd1, CSRRW, 5'd16, SYSTEM), 1'b1, 5'd16, retired);
        runInstr(iType(CSR_MINSTRET, 5'd0, CSRRS, 5'd15, SYSTEM), 1'b1, 5'd15, retired);
        runInstr(iType(12'h7C0, 5'd0, CSRRS, 5'd17, SYSTEM), 1'b1, 5'd17, 32'h0);
    endtask

    initial begin
        instr      = '0;
        instrValid = 1'b0;
        expPc      = '0;
        retired    = '0;
        squashNext = 1'b0;
        rngState   = 32'hfb6c6625;
        for (int i = 0; i < 32; i++) begin
            regModel[i] = '0;
        end
        resetState();
        arithOps();
        storeLoad();
        branchKinds();
        jumpLinks();
        csrAccess();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* tbClock.sv */
module tbClock (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HalfPeriod  = 20;
    localparam int ResetCycles = 5;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

/* rvCore.sv */
module rvCore (
    input  logic                clk,
    input  logic                arstN,
    input  rvIsaPkg::xlenT      instr,
    input  logic                instrValid,
    output rvIsaPkg::xlenT      memAddr,
    output rvIsaPkg::xlenT      memWdata,
    output logic                memRead,
    output rvCtrlPkg::memSizeT  memWrite,
    input  rvIsaPkg::xlenT      memRdata,
    output rvIsaPkg::xlenT      pc,
    output logic                retValid,
    output rvIsaPkg::regIdxT    retRd,
    output rvIsaPkg::xlenT      retData
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    ctrlIf ctrl();

    seqStateT state;
    xlenT     rs1Data;
    xlenT     rs2Data;
    xlenT     aluResult;
    xlenT     target;
    xlenT     csrRdata;
    xlenT     wbData;
    logic     taken;

    instrDecoder uDecoder (.state(state), .instr(instr), .ctrl(ctrl));

    regFile uRegFile (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .ctrl(ctrl),
        .wbData(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    aluUnit uAlu (
        .ctrl(ctrl), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .result(aluResult), .target(target), .taken(taken)
    );

    csrFile uCsr (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .ctrl(ctrl),
        .rs1Data(rs1Data), .squash(state == NOP), .csrRdata(csrRdata)
    );

    pcSequencer uSeq (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .taken(taken),
        .target(target), .pc(pc), .state(state)
    );

    always_comb begin
        if (ctrl.memToReg) wbData = memRdata;
        else if (ctrl.jump) wbData = pc + 32'd4;
        else if (ctrl.csrWe) wbData = csrRdata;
        else wbData = aluResult;
    end

    // Memory strobes only while an instruction is offered.
    assign memAddr  = aluResult;
    assign memWdata = rs2Data;
    assign memRead  = instrValid && ctrl.memRead;
    assign memWrite = instrValid ? ctrl.memWrite : IDLE;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            retValid <= 1'b0;
        end else begin
            retValid <= instrValid && ctrl.regWrite && ctrl.rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            retRd   <= ctrl.rd;
            retData <= wbData;
        end
    end

endmodule

/* pcSequencer.sv */
module pcSequencer (
    input  logic                clk,
    input  logic                arstN,
    input  logic                instrValid,
    input  logic                taken,
    input  rvIsaPkg::xlenT      target,
    output rvIsaPkg::xlenT      pc,
    output rvCtrlPkg::seqStateT state
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc    <= '0;
            state <= NORMAL;
        end else if (instrValid) begin
            case (state)
                NORMAL: begin
                    if (taken) begin
                        pc    <= target;
                        state <= NOP;
                    end else begin
                        pc <= pc + 32'd4;
                    end
                end
                // Squashed slot leaves pc alone.
                NOP: begin
                    state <= NORMAL;
                end
                default: begin
                    state <= NORMAL;
                end
            endcase
        end
    end

endmodule

/* csrFile.sv */
module csrFile (
    input  logic           clk,
    input  logic           arstN,
    input  logic           instrValid,
    ctrlIf.user            ctrl,
    input  rvIsaPkg::xlenT rs1Data,
    input  logic           squash,
    output rvIsaPkg::xlenT csrRdata
);
    import rvIsaPkg::*;

    xlenT mscratch;
    xlenT minstret;
    xlenT scratchNext;

    always_comb begin
        case (ctrl.csrAddr)
            CSR_MSCRATCH: csrRdata = mscratch;
            CSR_MINSTRET: csrRdata = minstret;
            default:      csrRdata = '0;
        endcase
    end

    always_comb begin
        case (ctrl.csrOp)
            CSRRW:   scratchNext = rs1Data;
            CSRRS:   scratchNext = mscratch | rs1Data;
            CSRRC:   scratchNext = mscratch & ~rs1Data;
            default: scratchNext = mscratch;
        endcase
    end

    // minstret is read-only, so only mscratch takes writes.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mscratch <= '0;
            minstret <= '0;
        end else if (instrValid) begin
            if (!squash) minstret <= minstret + 1'b1;
            if (ctrl.csrWe && ctrl.csrAddr == CSR_MSCRATCH) mscratch <= scratchNext;
        end
    end

endmodule

/* aluUnit.sv */
module aluUnit (
    ctrlIf.user            ctrl,
    input  rvIsaPkg::xlenT pc,
    input  rvIsaPkg::xlenT rs1Data,
    input  rvIsaPkg::xlenT rs2Data,
    output rvIsaPkg::xlenT result,
    output rvIsaPkg::xlenT target,
    output logic           taken
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    xlenT opB;
    logic condMet;

    assign opB = ctrl.aluSrc ? ctrl.imm : rs2Data;

    always_comb begin
        case (ctrl.aluOp)
            ADD:     result = rs1Data + opB;
            SUB:     result = rs1Data - opB;
            SLL:     result = rs1Data << opB[4:0];
            SLT:     result = {31'b0, $signed(rs1Data) < $signed(opB)};
            SLTU:    result = {31'b0, rs1Data < opB};
            XOR:     result = rs1Data ^ opB;
            SRL:     result = rs1Data >> opB[4:0];
            SRA:     result = $signed(rs1Data) >>> opB[4:0];
            OR:      result = rs1Data | opB;
            AND:     result = rs1Data & opB;
            PASSB:   result = opB;
            PCADD:   result = pc + opB;
            default: result = '0;
        endcase
    end

    always_comb begin
        case (ctrl.funct3)
            BEQ:     condMet = rs1Data == rs2Data;
            BNE:     condMet = rs1Data != rs2Data;
            BLT:     condMet = $signed(rs1Data) < $signed(rs2Data);
            BGE:     condMet = $signed(rs1Data) >= $signed(rs2Data);
            BLTU:    condMet = rs1Data < rs2Data;
            BGEU:    condMet = rs1Data >= rs2Data;
            default: condMet = 1'b0;
        endcase
    end

    assign taken = ctrl.jump || (ctrl.branch && condMet);

    // Jump target comes from the ALU sum, bit 0 dropped for JALR.
    assign target = ctrl.jump ? {result[31:1], 1'b0} : pc + ctrl.imm;

endmodule

/* regFile.sv */
module regFile (
    input  logic           clk,
    input  logic           arstN,
    input  logic           instrValid,
    ctrlIf.user            ctrl,
    input  rvIsaPkg::xlenT wbData,
    output rvIsaPkg::xlenT rs1Data,
    output rvIsaPkg::xlenT rs2Data
);
    import rvIsaPkg::*;

    // x0 has no storage.
    xlenT regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (instrValid && ctrl.regWrite && ctrl.rd != '0) begin
            regs[ctrl.rd] <= wbData;
        end
    end

    assign rs1Data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
    assign rs2Data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

endmodule

/* instrDecoder.sv */
module instrDecoder (
    input  rvCtrlPkg::seqStateT state,
    input  rvIsaPkg::xlenT      instr,
    ctrlIf.dec                  ctrl
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    opcodeT opcode;
    xlenT   immI;
    xlenT   immS;
    xlenT   immB;
    xlenT   immU;
    xlenT   immJ;
    aluOpT  arithOp;

    assign opcode      = instr[6:0];
    assign ctrl.rd     = instr[11:7];
    assign ctrl.funct3 = instr[14:12];
    assign ctrl.rs1    = instr[19:15];
    assign ctrl.rs2    = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Bit 30 picks SUB and SRA; immediates have no SUB.
    always_comb begin
        case (ctrl.funct3)
            F3_ADD:  arithOp = (opcode == OP && instr[30]) ? SUB : ADD;
            F3_SLL:  arithOp = SLL;
            F3_SLT:  arithOp = SLT;
            F3_SLTU: arithOp = SLTU;
            F3_XOR:  arithOp = XOR;
            F3_SR:   arithOp = instr[30] ? SRA : SRL;
            F3_OR:   arithOp = OR;
            default: arithOp = AND;
        endcase
    end

    always_comb begin
        ctrl.branch   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = IDLE;
        ctrl.aluOp    = ADD;
        ctrl.csrWe    = 1'b0;
        ctrl.csrOp    = '0;
        ctrl.csrAddr  = '0;
        ctrl.imm      = '0;
        if (state == NORMAL) begin
            case (opcode)
                LUI: begin
                    {ctrl.aluSrc, ctrl.regWrite} = 2'b11;
                    ctrl.aluOp = PASSB;
                    ctrl.imm   = immU;
                end
                AUIPC: begin
                    {ctrl.aluSrc, ctrl.regWrite} = 2'b11;
                    ctrl.aluOp = PCADD;
                    ctrl.imm   = immU;
                end
                // JAL forms pc plus imm in the ALU, JALR forms rs1 plus imm.
                JAL: begin
                    {ctrl.jump, ctrl.aluSrc, ctrl.regWrite} = 3'b111;
                    ctrl.aluOp = PCADD;
                    ctrl.imm   = immJ;
                end
                JALR: begin
                    {ctrl.jump, ctrl.aluSrc, ctrl.regWrite} = 3'b111;
                    ctrl.imm = immI;
                end
                BRANCH: begin
                    ctrl.branch = 1'b1;
                    ctrl.imm    = immB;
                end
                LOAD: begin
                    if (ctrl.funct3 == LW) begin
                        {ctrl.memRead, ctrl.memToReg, ctrl.aluSrc, ctrl.regWrite} = 4'b1111;
                        ctrl.imm = immI;
                    end
                end
                STORE: begin
                    ctrl.aluSrc = 1'b1;
                    ctrl.imm    = immS;
                    case (ctrl.funct3)
                        SB:      ctrl.memWrite = BYTE;
                        SH:      ctrl.memWrite = HALF;
                        SW:      ctrl.memWrite = WORD;
                        default: ctrl.memWrite = IDLE;
                    endcase
                end
                OP_IMM: begin
                    {ctrl.aluSrc, ctrl.regWrite} = 2'b11;
                    ctrl.aluOp = arithOp;
                    ctrl.imm   = immI;
                end
                OP: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = arithOp;
                end
                SYSTEM: begin
                    if (ctrl.funct3 inside {CSRRW, CSRRS, CSRRC}) begin
                        {ctrl.csrWe, ctrl.regWrite} = 2'b11;
                        ctrl.csrOp   = ctrl.funct3;
                        ctrl.csrAddr = instr[31:20];
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* ctrlIf.sv */
interface ctrlIf;
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic    branch;
    logic    jump;
    logic    memRead;
    logic    memToReg;
    logic    aluSrc;
    logic    regWrite;
    memSizeT memWrite;
    aluOpT   aluOp;
    logic    csrWe;
    funct3T  csrOp;
    csrAddrT csrAddr;
    xlenT    imm;
    regIdxT  rs1;
    regIdxT  rs2;
    regIdxT  rd;
    funct3T  funct3;

    modport dec (
        output branch, jump, memRead, memToReg, aluSrc, regWrite, memWrite, aluOp,
        output csrWe, csrOp, csrAddr, imm, rs1, rs2, rd, funct3
    );

    modport user (
        input branch, jump, memRead, memToReg, aluSrc, regWrite, memWrite, aluOp,
        input csrWe, csrOp, csrAddr, imm, rs1, rs2, rd, funct3
    );

endinterface

/* rvCtrlPkg.sv */
package rvCtrlPkg;

    // NOP squashes the instruction after a taken transfer.
    typedef enum logic {
        NORMAL = 1'b0,
        NOP    = 1'b1
    } seqStateT;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB,
        PCADD
    } aluOpT;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        BYTE = 2'b01,
        HALF = 2'b10,
        WORD = 2'b11
    } memSizeT;

endpackage

/* rvIsaPkg.sv */
package rvIsaPkg;

    typedef logic [31:0] xlenT;
    typedef logic [4:0]  regIdxT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;
    typedef logic [11:0] csrAddrT;

    // Major opcodes.
    localparam opcodeT LUI    = 7'b0110111;
    localparam opcodeT AUIPC  = 7'b0010111;
    localparam opcodeT JAL    = 7'b1101111;
    localparam opcodeT JALR   = 7'b1100111;
    localparam opcodeT BRANCH = 7'b1100011;
    localparam opcodeT LOAD   = 7'b0000011;
    localparam opcodeT STORE  = 7'b0100011;
    localparam opcodeT OP_IMM = 7'b0010011;
    localparam opcodeT OP     = 7'b0110011;
    localparam opcodeT SYSTEM = 7'b1110011;

    // Load and store widths.
    localparam funct3T SB = 3'b000;
    localparam funct3T SH = 3'b001;
    localparam funct3T SW = 3'b010;
    localparam funct3T LW = 3'b010;

    localparam funct3T BEQ  = 3'b000;
    localparam funct3T BNE  = 3'b001;
    localparam funct3T BLT  = 3'b100;
    localparam funct3T BGE  = 3'b101;
    localparam funct3T BLTU = 3'b110;
    localparam funct3T BGEU = 3'b111;

    // Integer op selects; F3_SR covers SRL and SRA.
    localparam funct3T F3_ADD  = 3'b000;
    localparam funct3T F3_SLL  = 3'b001;
    localparam funct3T F3_SLT  = 3'b010;
    localparam funct3T F3_SLTU = 3'b011;
    localparam funct3T F3_XOR  = 3'b100;
    localparam funct3T F3_SR   = 3'b101;
    localparam funct3T F3_OR   = 3'b110;
    localparam funct3T F3_AND  = 3'b111;

    localparam funct3T CSRRW = 3'b001;
    localparam funct3T CSRRS = 3'b010;
    localparam funct3T CSRRC = 3'b011;

    localparam csrAddrT CSR_MSCRATCH = 12'h340;
    localparam csrAddrT CSR_MINSTRET = 12'hB02;

endpackage
